/* Bender.yml */
package:
  name: snac_adapter

sources:
  # RTL in compile order
  - source/snac_pkg.sv
  - source/snac_pad_if.sv
  - source/snac_mode_regs.sv
  - source/strobe_divider.sv
  - source/serlatch_poller.sv
  - source/snac_port_map.sv
  - source/snac_adapter_top.sv

  # Testbench
  - target: simulation
    files:
      - dv/snac_pad_model.sv
      - dv/snac_adapter_tb.sv

/* snac_adapter_top.f */
source/snac_pkg.sv
source/snac_pad_if.sv
source/snac_mode_regs.sv
source/strobe_divider.sv
source/serlatch_poller.sv
source/snac_port_map.sv
source/snac_adapter_top.sv
dv/snac_pad_model.sv
dv/snac_adapter_tb.sv

/* dv/snac_adapter_tb.sv */
// Testbench for the SNAC adapter that runs a table of pad reads against a two-pad model
`timescale 1ns/1ps

module snac_adapter_tb
    import snac_pkg::*;
();

    localparam int NUM_TESTS       = 7;
    localparam int CLK_PERIOD      = 4;
    // Worst spacing of strobes at the 50 kHz compatibility rate
    localparam int SLOW_STB_CYCLES = 502;
    // Latch high, latch low, 16 bits of two phases, done, idle
    localparam int READ_STROBES    = 36;
    localparam int READ_CYCLES     = READ_STROBES * SLOW_STB_CYCLES;
    localparam int TIMEOUT_MARGIN  = 20000;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * 3 * READ_CYCLES + TIMEOUT_MARGIN;
    localparam int SETTLE_CYCLES   = 8;
    localparam int DISABLE_WINDOW  = 4 * SLOW_STB_CYCLES;

    logic                 i_clk;
    logic                 i_reset;
    logic [GC_TYPE_W-1:0] i_game_cont_type;
    logic [7:4]           i_cart_bk0_in;
    logic                 i_cart_pin31_in;
    logic [BTN_W-1:0]     o_p1_btn;
    logic [BTN_W-1:0]     o_p2_btn;
    logic                 o_busy;
    logic                 o_stb;
    logic                 o_cart_bk0_dir;
    logic [1:0]           o_cart_bk1_out;
    logic                 o_cart_pin30_out;
    logic                 o_cart_pin30_dir;
    logic                 o_cart_pin31_dir;

    logic [BTN_W-1:0]     pat1;
    logic [BTN_W-1:0]     pat2;
    logic                 dat1;
    logic                 dat2;

    // Stimulus table with expected words
    logic [GC_TYPE_W-1:0] tbl_type [NUM_TESTS];
    logic [BTN_W-1:0]     tbl_pat1 [NUM_TESTS];
    logic [BTN_W-1:0]     tbl_pat2 [NUM_TESTS];
    int                   tbl_len  [NUM_TESTS];
    logic [BTN_W-1:0]     tbl_exp1 [NUM_TESTS];
    logic [BTN_W-1:0]     tbl_exp2 [NUM_TESTS];

    integer seed = 28;
    int     err_cnt = 0;
    int     fail_tests = 0;
    int     cycle_cnt = 0;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Unused bank 0 pins float high
    assign i_cart_bk0_in = {2'b11, dat2, dat1};

    snac_adapter_top snac_adapter_top_inst (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_game_cont_type (i_game_cont_type),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .i_cart_pin31_in  (i_cart_pin31_in),
        .o_p1_btn         (o_p1_btn),
        .o_p2_btn         (o_p2_btn),
        .o_busy           (o_busy),
        .o_stb            (o_stb),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

    // Bank 1 bit 0 is the pad clock and bit 1 the latch
    snac_pad_model snac_pad_model_inst (
        .i_pad_clk  (o_cart_bk1_out[0]),
        .i_pad_lat  (o_cart_bk1_out[1]),
        .i_pattern1 (pat1),
        .i_pattern2 (pat2),
        .o_dat1     (dat1),
        .o_dat2     (dat2)
    );

    // Active-low pads with the first bit at bit 0 and zeros past the length
    function automatic logic [BTN_W-1:0] pressed_word(input logic [BTN_W-1:0] pattern,
                                                      input int len);
        logic [BTN_W-1:0] word;
        word = '0;
        for (int i = 0; i < len; i++) begin
            word[i] = ~pattern[i];
        end
        return word;
    endfunction

    task automatic add_entry(input int idx, input logic [GC_TYPE_W-1:0] gc,
                             input logic [BTN_W-1:0] p1, input logic [BTN_W-1:0] p2,
                             input int len);
        tbl_type[idx] = gc;
        tbl_pat1[idx] = p1;
        tbl_pat2[idx] = p2;
        tbl_len[idx]  = len;
        tbl_exp1[idx] = pressed_word(p1, len);
        tbl_exp2[idx] = pressed_word(p2, len);
    endtask

    task automatic fill_table;
        add_entry(0, GC_SNES, $random(seed), $random(seed), 16);
        add_entry(1, GC_SNES, 16'h5a3c, 16'hc3a5, 16);
        add_entry(2, GC_NES, $random(seed), $random(seed), 8);
        add_entry(3, GC_DB15, $random(seed), $random(seed), 12);
        add_entry(4, GC_DB15_FAST, $random(seed), $random(seed), 12);
        // Length zero marks the disabled entry
        add_entry(5, GC_DISABLED, $random(seed), $random(seed), 0);
        add_entry(6, GC_SNES_SWAP, $random(seed), $random(seed), 16);
    endtask

    task automatic check_value(input string name, input logic [BTN_W-1:0] got,
                               input logic [BTN_W-1:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Follows the pins at falling clock edges until busy falls
    task automatic watch_read(output int clk_falls, output int pin30_bad, output bit lat_seen);
        logic busy_prev;
        logic clk_prev;
        logic lat_prev;
        bit   done;
        clk_falls = 0;
        pin30_bad = 0;
        lat_seen  = 0;
        done      = 0;
        @(negedge i_clk);
        busy_prev = o_busy;
        clk_prev  = o_cart_bk1_out[0];
        lat_prev  = o_cart_bk1_out[1];
        while (!done) begin
            @(negedge i_clk);
            // Count pad clock falls from the end of the latch pulse
            if (lat_prev && !o_cart_bk1_out[1]) begin
                lat_seen  = 1;
                clk_falls = 0;
            end
            if (lat_seen && clk_prev && !o_cart_bk1_out[0]) begin
                clk_falls++;
            end
            if (o_busy && (o_cart_pin30_out !== o_cart_bk1_out[0])) begin
                pin30_bad++;
            end
            if (busy_prev && !o_busy) begin
                done = 1;
            end
            busy_prev = o_busy;
            clk_prev  = o_cart_bk1_out[0];
            lat_prev  = o_cart_bk1_out[1];
        end
    endtask

    task automatic check_disabled;
        int stb_cnt;
        int busy_cnt;
        stb_cnt  = 0;
        busy_cnt = 0;
        // Let the restart clear the divider and poller
        repeat (SETTLE_CYCLES) @(negedge i_clk);
        repeat (DISABLE_WINDOW) begin
            @(negedge i_clk);
            if (o_stb) stb_cnt++;
            if (o_busy) busy_cnt++;
        end
        assert (stb_cnt == 0) else begin
            $display("o_stb pulsed %0d times while the controller was disabled", stb_cnt);
            err_cnt++;
        end
        assert (busy_cnt == 0) else begin
            $display("o_busy was high for %0d cycles while disabled", busy_cnt);
            err_cnt++;
        end
        check_value("o_p1_btn", o_p1_btn, '0);
        check_value("o_p2_btn", o_p2_btn, '0);
    endtask

    task automatic report_test(input string label, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", label);
        end else begin
            $display("test %s: failed with %0d errors", label, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    // Run limit from the table length
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, no falling o_busy arrived", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin : run_tests
        int  falls;
        int  pin30_bad;
        bit  lat_seen;
        int  errs_before;
        i_clk            = 1'b0;
        i_reset          = 1'b1;
        i_game_cont_type = GC_DISABLED;
        i_cart_pin31_in  = 1'b1;
        pat1             = '1;
        pat2             = '1;
        fill_table();
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        // Reset state after a few clocks of normal operation
        repeat (SETTLE_CYCLES) @(negedge i_clk);
        errs_before = err_cnt;
        check_value("o_busy", o_busy, 0);
        check_value("o_p1_btn", o_p1_btn, '0);
        check_value("o_p2_btn", o_p2_btn, '0);
        check_value("o_cart_bk0_dir", o_cart_bk0_dir, 0);
        check_value("o_cart_pin30_dir", o_cart_pin30_dir, 1);
        check_value("o_cart_pin31_dir", o_cart_pin31_dir, 0);
        check_value("o_cart_bk1_out", o_cart_bk1_out, 2'b01);
        report_test("reset", errs_before);

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_cnt;
            @(posedge i_clk);
            i_game_cont_type <= tbl_type[t];
            pat1             <= tbl_pat1[t];
            pat2             <= tbl_pat2[t];
            if (tbl_len[t] == 0) begin
                check_disabled();
            end else begin
                // Skip one full read and check the next one
                watch_read(falls, pin30_bad, lat_seen);
                watch_read(falls, pin30_bad, lat_seen);
                check_value("o_p1_btn", o_p1_btn, tbl_exp1[t]);
                check_value("o_p2_btn", o_p2_btn, tbl_exp2[t]);
                assert (lat_seen) else begin
                    $display("no latch pulse seen on o_cart_bk1_out[1] during the read");
                    err_cnt++;
                end
                check_value("o_cart_bk1_out[0] falling edges", falls, tbl_len[t]);
                assert (pin30_bad == 0) else begin
                    $display("o_cart_pin30_out left the pad clock on %0d cycles", pin30_bad);
                    err_cnt++;
                end
            end
            report_test($sformatf("%0d type %h", t, tbl_type[t]), errs_before);
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 NUM_TESTS + 1, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/snac_pad_model.sv */
// Behavioral pair of shift-register game pads, driven from the adapter's cartridge pins in the testbench
`timescale 1ns/1ps

module snac_pad_model
    import snac_pkg::*;
(
    input  logic             i_pad_clk,
    input  logic             i_pad_lat,
    input  logic [BTN_W-1:0] i_pattern1,
    input  logic [BTN_W-1:0] i_pattern2,
    output logic             o_dat1,
    output logic             o_dat2
);

    // Released pads read all ones
    logic [BTN_W-1:0] sr1 = '1;
    logic [BTN_W-1:0] sr2 = '1;

    // Latch loads the active-low button levels, rising clock shifts
    always @(posedge i_pad_lat or posedge i_pad_clk) begin
        if (i_pad_lat) begin
            sr1 <= i_pattern1;
            sr2 <= i_pattern2;
        end else begin
            // Next button onto the line, ones fill in behind
            sr1 <= {1'b1, sr1[BTN_W-1:1]};
            sr2 <= {1'b1, sr2[BTN_W-1:1]};
        end
    end

    // First button comes out first
    assign o_dat1 = sr1[0];
    assign o_dat2 = sr2[0];

endmodule

/* source/snac_adapter_top.sv */
// Top level of the SNAC adapter, connects configuration, divider, poller and pin map
`timescale 1ns/1ps

module snac_adapter_top
    import snac_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic [GC_TYPE_W-1:0] i_game_cont_type,
    input  logic [7:4]           i_cart_bk0_in,
    input  logic                 i_cart_pin31_in,
    output logic [BTN_W-1:0]     o_p1_btn,
    output logic [BTN_W-1:0]     o_p2_btn,
    output logic                 o_busy,
    output logic                 o_stb,
    output logic                 o_cart_bk0_dir,
    output logic [1:0]           o_cart_bk1_out,
    output logic                 o_cart_pin30_out,
    output logic                 o_cart_pin30_dir,
    output logic                 o_cart_pin31_dir
);

    logic              restart;
    logic [STEP_W-1:0] step;
    logic [LEN_W-1:0]  read_len;
    logic              enable;

    // Pad lines between poller and pins
    snac_pad_if pad_if ();

    snac_mode_regs snac_mode_regs_inst (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_game_cont_type (i_game_cont_type),
        .o_restart        (restart),
        .o_step           (step),
        .o_read_len       (read_len),
        .o_enable         (enable)
    );

    strobe_divider strobe_divider_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_restart (restart),
        .i_step    (step),
        .o_stb     (o_stb)
    );

    serlatch_poller serlatch_poller_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_restart  (restart),
        .i_stb      (o_stb),
        .i_enable   (enable),
        .i_read_len (read_len),
        .pad        (pad_if.poller),
        .o_p1_btn   (o_p1_btn),
        .o_p2_btn   (o_p2_btn),
        .o_busy     (o_busy)
    );

    snac_port_map snac_port_map_inst (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .i_cart_pin31_in  (i_cart_pin31_in),
        .pad              (pad_if.port),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

endmodule

/* source/snac_port_map.sv */
// Configuration A cartridge pin mapping with registered directions, pad outputs and input resync
`timescale 1ns/1ps

module snac_port_map (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic [7:4] i_cart_bk0_in,
    // Pin 31 only served the DB15 second data line, kept as a plain input
    input  logic       i_cart_pin31_in,
    snac_pad_if.port   pad,
    output logic       o_cart_bk0_dir,
    output logic [1:0] o_cart_bk1_out,
    output logic       o_cart_pin30_out,
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir
);

    logic dat1_q;
    logic dat2_q;

    // Pad data resync, bank 0 bit 4 is pad 1 and bit 5 is pad 2
    always_ff @(posedge i_clk) begin
        dat1_q <= i_cart_bk0_in[4];
        dat2_q <= i_cart_bk0_in[5];
    end

    assign pad.pad_dat1 = dat1_q;
    assign pad.pad_dat2 = dat2_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // Bank 0 in, pin 30 out, pin 31 in
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
            // Idle levels, latch low and clock high
            o_cart_bk1_out   <= 2'b01;
            o_cart_pin30_out <= 1'b1;
        end else begin
            o_cart_bk0_dir   <= 1'b0;
            o_cart_pin30_dir <= 1'b1;
            o_cart_pin31_dir <= 1'b0;
            // Bit 1 is bank 1 pin 7 latch, bit 0 is pin 6 clock
            o_cart_bk1_out   <= {pad.pad_lat, pad.pad_clk};
            // Second pad clock copy
            o_cart_pin30_out <= pad.pad_clk;
        end
    end

endmodule

/* source/serlatch_poller.sv */
// Strobe-paced reader for two NES, SNES or DB15 shift-register pads on a shared clock and latch
`timescale 1ns/1ps

module serlatch_poller
    import snac_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_restart,
    input  logic              i_stb,
    input  logic              i_enable,
    input  logic [LEN_W-1:0]  i_read_len,
    snac_pad_if.poller        pad,
    output logic [BTN_W-1:0]  o_p1_btn,
    output logic [BTN_W-1:0]  o_p2_btn,
    output logic              o_busy
);

    logic [POLL_ST_W-1:0] state_q;
    logic [LEN_W-1:0]     bit_cnt_q;
    logic                 clk_q;
    logic                 lat_q;
    logic                 dat1_q;
    logic                 dat2_q;
    logic [BTN_W-1:0]     p1_shift_q;
    logic [BTN_W-1:0]     p2_shift_q;
    logic                 last_bit;

    assign pad.pad_clk = clk_q;
    assign pad.pad_lat = lat_q;

    // Last bit of the read is being clocked in
    assign last_bit = (bit_cnt_q == LEN_W'(i_read_len - 1'b1));

    // Sample register for both data lines
    always_ff @(posedge i_clk) begin
        dat1_q <= pad.pad_dat1;
        dat2_q <= pad.pad_dat2;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_restart || !i_enable) begin
            // Pads idle with clock high and latch low
            state_q   <= POLL_IDLE;
            bit_cnt_q <= '0;
            clk_q     <= 1'b1;
            lat_q     <= 1'b0;
            o_busy    <= 1'b0;
            o_p1_btn  <= '0;
            o_p2_btn  <= '0;
        end else if (i_stb) begin
            case (state_q)
                POLL_IDLE: begin
                    // Latch high loads both pads
                    lat_q      <= 1'b1;
                    o_busy     <= 1'b1;
                    p1_shift_q <= '0;
                    p2_shift_q <= '0;
                    state_q    <= POLL_LAT;
                end
                POLL_LAT: begin
                    // First bit now sits on the data lines
                    lat_q     <= 1'b0;
                    bit_cnt_q <= '0;
                    state_q   <= POLL_CLK_LO;
                end
                POLL_CLK_LO: begin
                    clk_q   <= 1'b0;
                    state_q <= POLL_CLK_HI;
                end
                POLL_CLK_HI: begin
                    // Take the current bit, the rising clock shifts the next one out
                    clk_q <= 1'b1;
                    p1_shift_q[bit_cnt_q[BTN_IDX_W-1:0]] <= ~dat1_q;
                    p2_shift_q[bit_cnt_q[BTN_IDX_W-1:0]] <= ~dat2_q;
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (last_bit) begin
                        state_q <= POLL_DONE;
                    end else begin
                        state_q <= POLL_CLK_LO;
                    end
                end
                POLL_DONE: begin
                    // Publish both words as busy drops
                    o_busy   <= 1'b0;
                    o_p1_btn <= p1_shift_q;
                    o_p2_btn <= p2_shift_q;
                    state_q  <= POLL_IDLE;
                end
                default: begin
                    state_q <= POLL_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/strobe_divider.sv */
// Fractional divider, pulses the polling strobe on each phase accumulator carry
`timescale 1ns/1ps

module strobe_divider
    import snac_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_restart,
    input  logic [STEP_W-1:0] i_step,
    output logic              o_stb
);

    logic [STEP_W-1:0] acc_q;
    logic [STEP_W:0]   acc_sum;

    // Extra top bit is the carry out
    assign acc_sum = {1'b0, acc_q} + {1'b0, i_step};

    always_ff @(posedge i_clk) begin
        if (i_reset || i_restart) begin
            // Start the phase from zero on a rate change
            acc_q <= '0;
            o_stb <= 1'b0;
        end else begin
            acc_q <= acc_sum[STEP_W-1:0];
            o_stb <= acc_sum[STEP_W];
        end
    end

endmodule

/* source/snac_mode_regs.sv */
// Registers the controller type, flags a restart on change and picks polling rate and read length
`timescale 1ns/1ps

module snac_mode_regs
    import snac_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic [GC_TYPE_W-1:0] i_game_cont_type,
    output logic                 o_restart,
    output logic [STEP_W-1:0]    o_step,
    output logic [LEN_W-1:0]     o_read_len,
    output logic                 o_enable
);

    logic [GC_TYPE_W-1:0] type_q;

    // Copy of the code used for change detection
    always_ff @(posedge i_clk) begin
        type_q <= i_game_cont_type;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_restart  <= 1'b1;
            o_enable   <= 1'b0;
            o_step     <= '0;
            o_read_len <= '0;
        end else begin
            // Pulse for one clock on any type change
            o_restart <= (type_q != i_game_cont_type);
            case (i_game_cont_type)
                GC_DB15: begin
                    o_enable   <= 1'b1;
                    o_step     <= STEP_SERLATCH_NORMAL;
                    o_read_len <= LEN_DB15;
                end
                GC_DB15_FAST: begin
                    o_enable   <= 1'b1;
                    o_step     <= STEP_SERLATCH_FAST;
                    o_read_len <= LEN_DB15;
                end
                GC_NES: begin
                    o_enable   <= 1'b1;
                    o_step     <= STEP_SNES_COMPAT;
                    o_read_len <= LEN_NES;
                end
                GC_SNES, GC_SNES_SWAP: begin
                    o_enable   <= 1'b1;
                    o_step     <= STEP_SNES_COMPAT;
                    o_read_len <= LEN_SNES;
                end
                default: begin
                    // Zero step keeps the divider silent
                    o_enable   <= 1'b0;
                    o_step     <= '0;
                    o_read_len <= '0;
                end
            endcase
        end
    end

endmodule

/* source/snac_pad_if.sv */
// Shared pad clock, latch and the two pad data lines between the poller and the pin map
`timescale 1ns/1ps

interface snac_pad_if;

    // Shared by both pads, driven by the poller
    logic pad_clk;
    logic pad_lat;

    // Resynchronized pad data, active low
    logic pad_dat1;
    logic pad_dat2;

    // Poller side
    modport poller (
        output pad_clk,
        output pad_lat,
        input  pad_dat1,
        input  pad_dat2
    );

    // Cartridge pin side
    modport port (
        input  pad_clk,
        input  pad_lat,
        output pad_dat1,
        output pad_dat2
    );

endinterface

/* source/snac_pkg.sv */
// Shared constants for the SNAC adapter: controller codes, polling steps, read lengths, widths
package snac_pkg;

    // Controller type code width and the supported codes
    localparam int GC_TYPE_W = 5;
    localparam logic [GC_TYPE_W-1:0] GC_DISABLED  = 5'h00;
    localparam logic [GC_TYPE_W-1:0] GC_DB15      = 5'h01;
    localparam logic [GC_TYPE_W-1:0] GC_NES       = 5'h02;
    localparam logic [GC_TYPE_W-1:0] GC_SNES      = 5'h03;
    localparam logic [GC_TYPE_W-1:0] GC_DB15_FAST = 5'h09;
    localparam logic [GC_TYPE_W-1:0] GC_SNES_SWAP = 5'h0B;

    // Core clock and phase accumulator
    localparam longint unsigned CLK_FREQ_HZ = 50_000_000;
    localparam int STEP_W = 32;
    localparam longint unsigned STEP_MAX = 64'h0000_0000_ffff_ffff;

    // Step for a strobe at twice the polling rate, fractional form
    function automatic logic [STEP_W-1:0] calc_step(input longint unsigned poll_hz);
        longint unsigned full;
        full = ((STEP_MAX / (CLK_FREQ_HZ / 1000)) * poll_hz * 2) / 1000;
        return full[STEP_W-1:0];
    endfunction

    // 200 kHz, 400 kHz and 50 kHz polling
    localparam logic [STEP_W-1:0] STEP_SERLATCH_NORMAL = calc_step(200_000);
    localparam logic [STEP_W-1:0] STEP_SERLATCH_FAST   = calc_step(400_000);
    localparam logic [STEP_W-1:0] STEP_SNES_COMPAT     = calc_step(50_000);

    // Bits read per pad
    localparam int LEN_W = 5;
    localparam logic [LEN_W-1:0] LEN_NES  = 5'd8;
    localparam logic [LEN_W-1:0] LEN_SNES = 5'd16;
    localparam logic [LEN_W-1:0] LEN_DB15 = 5'd12;

    // Button word
    localparam int BTN_W = 16;
    localparam int BTN_IDX_W = $clog2(BTN_W);

    // Poller FSM states
    localparam int POLL_ST_W = 3;
    localparam logic [POLL_ST_W-1:0] POLL_IDLE   = 3'd0;
    localparam logic [POLL_ST_W-1:0] POLL_LAT    = 3'd1;
    localparam logic [POLL_ST_W-1:0] POLL_CLK_LO = 3'd2;
    localparam logic [POLL_ST_W-1:0] POLL_CLK_HI = 3'd3;
    localparam logic [POLL_ST_W-1:0] POLL_DONE   = 3'd4;

endpackage
